// File: run_sim.sh
#!/bin/sh
# compile and run the thread unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module thread_unit_tb -f thread_unit.f -o thread_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/thread_unit_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // held over two rising edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: thread_base_regs.sv
`timescale 1ns/1ps

module thread_base_regs (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 cfg_we,
  input  thread_msg_pkg::cfg_reg_e             cfg_sel,
  input  logic [thread_sizes_pkg::ADDR_W-1:0]  cfg_wdata,
  output thread_sizes_pkg::base_cfg_t          cfg
);

  // all bases zero and dispatcher offline out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.code_base   <= '0;
      cfg.data_base   <= '0;
      cfg.disp_enable <= 1'b0;
    end else if (cfg_we) begin
      case (cfg_sel)
        thread_msg_pkg::CFG_CODE_BASE: begin
          cfg.code_base <= cfg_wdata;
        end
        thread_msg_pkg::CFG_DATA_BASE: begin
          cfg.data_base <= cfg_wdata;
        end
        thread_msg_pkg::CFG_ENABLE: begin
          // only bit 0 is meaningful
          cfg.disp_enable <= cfg_wdata[0];
        end
        default: begin
          // unmapped select, write is lost
        end
      endcase
    end
  end

endmodule

// File: thread_ctlr.sv
`timescale 1ns/1ps

module thread_ctlr (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 alu_begin,
  input  logic [31:0]                          command,
  input  logic [thread_sizes_pkg::DATA_W-1:0]  src0,
  input  logic [thread_sizes_pkg::DATA_W-1:0]  src1,
  input  thread_sizes_pkg::base_cfg_t          cfg,
  input  thread_msg_pkg::disp_rsp_t            rsp,
  output thread_msg_pkg::disp_req_t            req,
  output logic                                 next_state,
  output logic                                 op_ok
);

  thread_msg_pkg::cmd_op_e     cmd_op;
  thread_msg_pkg::cmd_op_e     pend_op;
  thread_msg_pkg::ctlr_state_e state;
  thread_msg_pkg::cpu_msg_e    pend_msg;
  thread_sizes_pkg::addr_t     fork_addr;
  thread_sizes_pkg::addr_t     stop_addr;
  thread_sizes_pkg::data_t     fork_data;
  thread_sizes_pkg::data_t     stop_data;
  thread_sizes_pkg::addr_t     req_addr;
  thread_sizes_pkg::data_t     req_data;
  logic                        armed;
  logic                        issue;
  logic                        rsp_match;
  logic                        rsp_ok;

  assign cmd_op = thread_msg_pkg::cmd_op_e'(command[31:28]);

  // only fork and stop reach the dispatcher, and only while it is online
  assign issue = alu_begin && armed && cfg.disp_enable &&
                 (cmd_op == thread_msg_pkg::CMD_FORK || cmd_op == thread_msg_pkg::CMD_STOP);

  // fork names the code start, stop names the header below it
  assign fork_addr = src0 + cfg.code_base;
  assign stop_addr = src0 + cfg.code_base - thread_sizes_pkg::THREAD_HEADER_SPACE;
  assign fork_data = (src1 == '0) ? '0 : src1 + cfg.data_base;
  assign stop_data = (src1 == '0) ? '0 :
                     src1 + cfg.data_base - thread_sizes_pkg::THREAD_HEADER_SPACE;

  // accept only a reply of the kind that matches the pending op
  always_comb begin
    rsp_match = 1'b0;
    rsp_ok    = 1'b0;
    if (rsp.valid) begin
      case (pend_op)
        thread_msg_pkg::CMD_FORK: begin
          rsp_match = (rsp.msg == thread_msg_pkg::MSG_FORK_DONE) ||
                      (rsp.msg == thread_msg_pkg::MSG_FORK_FAIL);
          rsp_ok    = (rsp.msg == thread_msg_pkg::MSG_FORK_DONE);
        end
        thread_msg_pkg::CMD_STOP: begin
          rsp_match = (rsp.msg == thread_msg_pkg::MSG_STOP_DONE) ||
                      (rsp.msg == thread_msg_pkg::MSG_STOP_MISS);
          rsp_ok    = (rsp.msg == thread_msg_pkg::MSG_STOP_DONE);
        end
        default: begin
        end
      endcase
    end
  end

  // request payload, captured when the op is accepted
  always_ff @(posedge clk) begin
    if (state == thread_msg_pkg::IDLE && issue) begin
      pend_op  <= cmd_op;
      req_addr <= (cmd_op == thread_msg_pkg::CMD_FORK) ? fork_addr : stop_addr;
      req_data <= (cmd_op == thread_msg_pkg::CMD_FORK) ? fork_data : stop_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= thread_msg_pkg::IDLE;
      armed <= 1'b1;
      op_ok <= 1'b0;
    end else begin
      case (state)
        thread_msg_pkg::IDLE: begin
          // rearm once the core has dropped alu_begin
          if (!alu_begin) begin
            armed <= 1'b1;
          end
          if (issue) begin
            state <= thread_msg_pkg::SEND;
          end
        end
        thread_msg_pkg::SEND: begin
          state <= thread_msg_pkg::WAIT;
        end
        thread_msg_pkg::WAIT: begin
          // no timeout, the dispatcher always answers
          if (rsp_match) begin
            state <= thread_msg_pkg::ADVANCE;
            op_ok <= rsp_ok;
          end
        end
        thread_msg_pkg::ADVANCE: begin
          state <= thread_msg_pkg::IDLE;
          op_ok <= 1'b0;
          armed <= 1'b0;
        end
        default: begin
          state <= thread_msg_pkg::IDLE;
        end
      endcase
    end
  end

  assign pend_msg = (pend_op == thread_msg_pkg::CMD_FORK) ? thread_msg_pkg::MSG_FORK_THRD :
                                                            thread_msg_pkg::MSG_STOP_THRD;

  assign req.valid = (state == thread_msg_pkg::SEND);
  assign req.msg   = req.valid ? pend_msg : thread_msg_pkg::MSG_NONE;
  assign req.addr  = req_addr;
  assign req.data  = req_data;

  assign next_state = (state == thread_msg_pkg::ADVANCE);

endmodule

// File: thread_dispatcher.sv
`timescale 1ns/1ps

module thread_dispatcher (
  input  logic                                     clk,
  input  logic                                     rst,
  input  thread_sizes_pkg::base_cfg_t              cfg,
  input  thread_msg_pkg::disp_req_t                req,
  output thread_msg_pkg::disp_rsp_t                rsp,
  output logic [thread_sizes_pkg::SLOT_CNT_W-1:0]  active_count
);

  typedef struct packed {
    thread_sizes_pkg::addr_t hdr;
    thread_sizes_pkg::data_t arg;
  } slot_t;

  thread_msg_pkg::disp_req_t                 req_in;
  thread_msg_pkg::disp_req_t                 pipe [thread_sizes_pkg::DISP_LATENCY];
  thread_msg_pkg::disp_req_t                 last;
  slot_t                                     slots [thread_sizes_pkg::THREAD_SLOTS];
  logic [thread_sizes_pkg::THREAD_SLOTS-1:0] slot_active;
  thread_sizes_pkg::slot_idx_t               free_idx;
  thread_sizes_pkg::slot_idx_t               match_idx;
  logic                                      free_found;
  logic                                      match_found;
  logic                                      do_fork;
  logic                                      do_stop;

  // offline dispatcher drops whatever arrives
  always_comb begin
    req_in       = req;
    req_in.valid = req.valid && cfg.disp_enable;
  end

  // fixed latency delay line
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < thread_sizes_pkg::DISP_LATENCY; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= req_in;
      for (int i = 1; i < thread_sizes_pkg::DISP_LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign last = pipe[thread_sizes_pkg::DISP_LATENCY-1];

  // lowest free slot, and the slot holding the stop header
  always_comb begin
    free_found  = 1'b0;
    free_idx    = '0;
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = thread_sizes_pkg::THREAD_SLOTS - 1; i >= 0; i--) begin
      if (!slot_active[i]) begin
        free_found = 1'b1;
        free_idx   = thread_sizes_pkg::slot_idx_t'(i);
      end
      if (slot_active[i] && slots[i].hdr == last.addr) begin
        match_found = 1'b1;
        match_idx   = thread_sizes_pkg::slot_idx_t'(i);
      end
    end
  end

  assign do_fork = last.valid && (last.msg == thread_msg_pkg::MSG_FORK_THRD);
  assign do_stop = last.valid && (last.msg == thread_msg_pkg::MSG_STOP_THRD);

  // reply leaves in the same cycle the table is updated
  always_comb begin
    rsp.valid = do_fork || do_stop;
    rsp.msg   = thread_msg_pkg::MSG_NONE;
    if (do_fork) begin
      rsp.msg = free_found ? thread_msg_pkg::MSG_FORK_DONE : thread_msg_pkg::MSG_FORK_FAIL;
    end else if (do_stop) begin
      rsp.msg = match_found ? thread_msg_pkg::MSG_STOP_DONE : thread_msg_pkg::MSG_STOP_MISS;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_active <= '0;
    end else if (do_fork && free_found) begin
      slot_active[free_idx] <= 1'b1;
    end else if (do_stop && match_found) begin
      slot_active[match_idx] <= 1'b0;
    end
  end

  // table keeps the header address, not the code address
  always_ff @(posedge clk) begin
    if (do_fork && free_found) begin
      slots[free_idx].hdr <= last.addr - thread_sizes_pkg::THREAD_HEADER_SPACE;
      slots[free_idx].arg <= last.data;
    end
  end

  always_comb begin
    active_count = '0;
    for (int i = 0; i < thread_sizes_pkg::THREAD_SLOTS; i++) begin
      if (slot_active[i]) begin
        active_count = active_count + 1'b1;
      end
    end
  end

endmodule

// File: thread_msg_pkg.sv
package thread_msg_pkg;

  // opcode field, command[31:28]
  typedef enum logic [3:0] {
    CMD_NOP  = 4'h0,
    CMD_FORK = 4'h1,
    CMD_STOP = 4'h2
  } cmd_op_e;

  // core to dispatcher requests, dispatcher replies with bit 7 set
  typedef enum logic [7:0] {
    MSG_NONE      = 8'h00,
    MSG_FORK_THRD = 8'h01,
    MSG_STOP_THRD = 8'h02,
    MSG_FORK_DONE = 8'h81,
    MSG_FORK_FAIL = 8'h82,
    MSG_STOP_DONE = 8'h83,
    MSG_STOP_MISS = 8'h84
  } cpu_msg_e;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT,
    ADVANCE
  } ctlr_state_e;

  typedef enum logic [1:0] {
    CFG_CODE_BASE = 2'd0,
    CFG_DATA_BASE = 2'd1,
    CFG_ENABLE    = 2'd2
  } cfg_reg_e;

  typedef struct packed {
    logic                     valid;
    cpu_msg_e                 msg;
    thread_sizes_pkg::addr_t  addr;
    thread_sizes_pkg::data_t  data;
  } disp_req_t;

  typedef struct packed {
    logic     valid;
    cpu_msg_e msg;
  } disp_rsp_t;

endpackage

// File: thread_sizes_pkg.sv
package thread_sizes_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // dispatcher table
  localparam int THREAD_SLOTS = 4;
  localparam int SLOT_CNT_W = 3;
  localparam int SLOT_IDX_W = $clog2(THREAD_SLOTS);

  // request valid to reply valid, in clk cycles
  localparam int DISP_LATENCY = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

  // bytes of thread header ahead of the thread code
  localparam addr_t THREAD_HEADER_SPACE = addr_t'(16);

  // bases used by the controller address math
  typedef struct packed {
    addr_t code_base;
    addr_t data_base;
    logic  disp_enable;
  } base_cfg_t;

endpackage

// File: thread_unit.f
thread_sizes_pkg.sv
thread_msg_pkg.sv
thread_base_regs.sv
thread_ctlr.sv
thread_dispatcher.sv
thread_unit_top.sv
tb_clock_gen.sv
thread_unit_props.sv
thread_unit_tb.sv

// File: thread_unit_props.sv
`timescale 1ns/1ps

module thread_unit_props (
  input logic                      clk,
  input logic                      rst,
  input thread_msg_pkg::disp_req_t req,
  input thread_msg_pkg::disp_rsp_t rsp,
  input logic                      next_state
);

  // one request per op, one cycle wide
  req_single: assert property (@(posedge clk) disable iff (rst) req.valid |=> !req.valid)
    else $error("request valid held for two cycles");

  adv_single: assert property (@(posedge clk) disable iff (rst) next_state |=> !next_state)
    else $error("next_state held for two cycles");

  // advance only follows a dispatcher reply
  adv_after_rsp: assert property (@(posedge clk) disable iff (rst)
    next_state |-> $past(rsp.valid))
    else $error("next_state without a reply in the previous cycle");

endmodule

bind thread_ctlr thread_unit_props u_props (
  .clk        (clk),
  .rst        (rst),
  .req        (req),
  .rsp        (rsp),
  .next_state (next_state)
);

// File: thread_unit_tb.sv
`timescale 1ns/1ps

module thread_unit_tb;

  localparam int OP_TIMEOUT = 50;
  localparam int RESET_TIMEOUT = 20;

  typedef struct packed {
    logic                                    ok;
    logic [thread_sizes_pkg::SLOT_CNT_W-1:0] count;
  } result_t;

  logic                                    clk;
  logic                                    rst;
  logic                                    cfg_we;
  thread_msg_pkg::cfg_reg_e                cfg_sel;
  thread_sizes_pkg::addr_t                 cfg_wdata;
  logic                                    alu_begin;
  logic [31:0]                             command;
  thread_sizes_pkg::data_t                 src0;
  thread_sizes_pkg::data_t                 src1;
  logic                                    next_state;
  logic                                    op_ok;
  logic [thread_sizes_pkg::SLOT_CNT_W-1:0] active_count;
  thread_msg_pkg::disp_req_t               req_mon;

  // model of the dispatcher table
  thread_sizes_pkg::addr_t                 model_code_base;
  thread_sizes_pkg::addr_t                 model_data_base;
  thread_sizes_pkg::addr_t                 model_hdr [thread_sizes_pkg::THREAD_SLOTS];
  logic                                    model_act [thread_sizes_pkg::THREAD_SLOTS];
  logic [thread_sizes_pkg::SLOT_CNT_W-1:0] model_cnt;

  thread_msg_pkg::disp_req_t               req_q [$];
  result_t                                 res_q [$];
  thread_msg_pkg::disp_req_t               want_req;
  result_t                                 want_res;
  integer                                  seed;

  tb_clock_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  thread_unit_top UUT (
    .clk          (clk),
    .rst          (rst),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_wdata    (cfg_wdata),
    .alu_begin    (alu_begin),
    .command      (command),
    .src0         (src0),
    .src1         (src1),
    .next_state   (next_state),
    .op_ok        (op_ok),
    .active_count (active_count),
    .req_mon      (req_mon)
  );

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_error($sformatf("[FAIL] t=%0t %s", $time, msg));
  endtask

  // predicts request and outcome and updates the model table
  function automatic logic predict(input thread_msg_pkg::cmd_op_e op,
                                   input thread_sizes_pkg::data_t s0,
                                   input thread_sizes_pkg::data_t s1,
                                   output thread_sizes_pkg::addr_t addr,
                                   output thread_sizes_pkg::data_t data);
    int slot;
    slot = -1;
    if (op == thread_msg_pkg::CMD_FORK) begin
      addr = s0 + model_code_base;
      data = (s1 == 0) ? '0 : s1 + model_data_base;
      for (int i = thread_sizes_pkg::THREAD_SLOTS - 1; i >= 0; i--) begin
        if (!model_act[i]) begin
          slot = i;
        end
      end
      if (slot >= 0) begin
        model_act[slot] = 1'b1;
        model_hdr[slot] = addr - 32'd16;
        model_cnt++;
      end
    end else begin
      addr = s0 + model_code_base - 32'd16;
      data = (s1 == 0) ? '0 : s1 + model_data_base - 32'd16;
      for (int i = thread_sizes_pkg::THREAD_SLOTS - 1; i >= 0; i--) begin
        if (model_act[i] && model_hdr[i] == addr) begin
          slot = i;
        end
      end
      if (slot >= 0) begin
        model_act[slot] = 1'b0;
        model_cnt--;
      end
    end
    return (slot >= 0);
  endfunction

  task automatic write_cfg(input thread_msg_pkg::cfg_reg_e sel,
                           input thread_sizes_pkg::addr_t value);
    cfg_we = 1'b1;
    cfg_sel = sel;
    cfg_wdata = value;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // one thread command held until next_state
  task automatic run_op(input thread_msg_pkg::cmd_op_e op, input thread_sizes_pkg::data_t s0,
                        input thread_sizes_pkg::data_t s1, output logic ok_seen);
    thread_msg_pkg::disp_req_t exp_req;
    result_t                   exp_res;
    thread_sizes_pkg::addr_t   exp_addr;
    thread_sizes_pkg::data_t   exp_data;
    int                        cycles;
    exp_res.ok = predict(op, s0, s1, exp_addr, exp_data);
    exp_res.count = model_cnt;
    exp_req.valid = 1'b1;
    exp_req.msg = (op == thread_msg_pkg::CMD_FORK) ? thread_msg_pkg::MSG_FORK_THRD :
                                                     thread_msg_pkg::MSG_STOP_THRD;
    exp_req.addr = exp_addr;
    exp_req.data = exp_data;
    req_q.push_back(exp_req);
    res_q.push_back(exp_res);
    command = {op, 28'h0};
    src0 = s0;
    src1 = s1;
    alu_begin = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > OP_TIMEOUT) begin
        stop_with_error("timeout while waiting for next_state after a thread command");
      end
    end while (!next_state);
    assert (cycles == 5)
      else report_mismatch($sformatf("next_state after %0d cycles, expected 5", cycles));
    ok_seen = op_ok;
    alu_begin = 1'b0;
    // controller must see alu_begin low before the next op
    repeat (2) @(negedge clk);
  endtask

  always @(negedge clk) begin
    if (!rst && req_mon.valid) begin
      assert (req_q.size() != 0) else report_mismatch("request seen with none expected");
      want_req = req_q.pop_front();
      assert (req_mon == want_req)
        else report_mismatch($sformatf("req msg %h addr %h data %h, expected %h %h %h",
          req_mon.msg, req_mon.addr, req_mon.data, want_req.msg, want_req.addr, want_req.data));
    end
    if (!rst && next_state) begin
      assert (res_q.size() != 0) else report_mismatch("next_state seen with none expected");
      want_res = res_q.pop_front();
      assert (op_ok == want_res.ok && active_count == want_res.count)
        else report_mismatch($sformatf("op_ok %b count %0d, expected %b %0d",
          op_ok, active_count, want_res.ok, want_res.count));
    end
    if (!rst && !next_state) begin
      assert (!op_ok) else report_mismatch("op_ok high outside a next_state pulse");
    end
  end

  initial begin
    logic                    ok_seen;
    int                      waited;
    logic [31:0]             r;
    logic [31:0]             r2;
    thread_sizes_pkg::data_t s0_rand;
    thread_sizes_pkg::data_t s1_rand;
    logic [thread_sizes_pkg::SLOT_CNT_W-1:0] count_before;
    seed = 32'h3d9b;
    cfg_we = 1'b0;
    cfg_sel = thread_msg_pkg::CFG_CODE_BASE;
    cfg_wdata = '0;
    alu_begin = 1'b0;
    command = '0;
    src0 = '0;
    src1 = '0;
    model_code_base = 32'h0001_0000;
    model_data_base = 32'h0002_0000;
    model_cnt = '0;
    for (int i = 0; i < thread_sizes_pkg::THREAD_SLOTS; i++) begin
      model_act[i] = 1'b0;
      model_hdr[i] = '0;
    end
    waited = 0;
    @(negedge clk);
    while (rst) begin
      @(negedge clk);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        stop_with_error("timeout while waiting for reset to be released");
      end
    end

    // dispatcher still offline
    command = {thread_msg_pkg::CMD_FORK, 28'h0};
    src0 = 32'h100;
    src1 = 32'h5;
    alu_begin = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (!req_mon.valid && !next_state)
        else report_mismatch("request or next_state while the dispatcher is disabled");
    end
    alu_begin = 1'b0;
    @(negedge clk);

    write_cfg(thread_msg_pkg::CFG_CODE_BASE, model_code_base);
    write_cfg(thread_msg_pkg::CFG_DATA_BASE, model_data_base);
    write_cfg(thread_msg_pkg::CFG_ENABLE, 32'h1);

    count_before = model_cnt;
    run_op(thread_msg_pkg::CMD_FORK, 32'h100, 32'h40, ok_seen);
    assert (ok_seen && active_count == count_before + 1)
      else report_mismatch("first fork not accepted or count not raised");
    run_op(thread_msg_pkg::CMD_FORK, 32'h140, 32'h0, ok_seen);
    assert (ok_seen) else report_mismatch("fork with zero argument not accepted");

    // fill the table and fork one too many
    run_op(thread_msg_pkg::CMD_FORK, 32'h180, 32'h11, ok_seen);
    run_op(thread_msg_pkg::CMD_FORK, 32'h1c0, 32'h22, ok_seen);
    run_op(thread_msg_pkg::CMD_FORK, 32'h200, 32'h33, ok_seen);
    assert (!ok_seen && active_count == thread_sizes_pkg::THREAD_SLOTS)
      else report_mismatch("fork into a full table was accepted");

    run_op(thread_msg_pkg::CMD_STOP, 32'h140, 32'h7, ok_seen);
    assert (ok_seen && active_count == thread_sizes_pkg::THREAD_SLOTS - 1)
      else report_mismatch("stop of a live thread failed");
    run_op(thread_msg_pkg::CMD_STOP, 32'h7f0, 32'h0, ok_seen);
    assert (!ok_seen && active_count == thread_sizes_pkg::THREAD_SLOTS - 1)
      else report_mismatch("stop of an unknown thread was accepted");

    // narrow src0 range so stops hit live threads
    for (int n = 0; n < 40; n++) begin
      r = $random(seed);
      r2 = $random(seed);
      s0_rand = 32'h100 + {r2[2:0], 6'h0};
      s1_rand = r[1] ? 32'h0 : $random(seed);
      run_op(r[0] ? thread_msg_pkg::CMD_FORK : thread_msg_pkg::CMD_STOP,
             s0_rand, s1_rand, ok_seen);
    end

    assert (req_q.size() == 0 && res_q.size() == 0)
      else stop_with_error("some expected requests or replies were never seen");
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: thread_unit_top.sv
`timescale 1ns/1ps

module thread_unit_top (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     cfg_we,
  input  thread_msg_pkg::cfg_reg_e                 cfg_sel,
  input  logic [thread_sizes_pkg::ADDR_W-1:0]      cfg_wdata,
  input  logic                                     alu_begin,
  input  logic [31:0]                              command,
  input  logic [thread_sizes_pkg::DATA_W-1:0]      src0,
  input  logic [thread_sizes_pkg::DATA_W-1:0]      src1,
  output logic                                     next_state,
  output logic                                     op_ok,
  output logic [thread_sizes_pkg::SLOT_CNT_W-1:0]  active_count,
  output thread_msg_pkg::disp_req_t                req_mon
);

  thread_sizes_pkg::base_cfg_t cfg;
  thread_msg_pkg::disp_rsp_t   rsp;

  thread_base_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  // request wire doubles as the debug monitor
  thread_ctlr u_ctlr (
    .clk        (clk),
    .rst        (rst),
    .alu_begin  (alu_begin),
    .command    (command),
    .src0       (src0),
    .src1       (src1),
    .cfg        (cfg),
    .rsp        (rsp),
    .req        (req_mon),
    .next_state (next_state),
    .op_ok      (op_ok)
  );

  thread_dispatcher u_disp (
    .clk          (clk),
    .rst          (rst),
    .cfg          (cfg),
    .req          (req_mon),
    .rsp          (rsp),
    .active_count (active_count)
  );

endmodule
